//--- hw/detector_params.svh
`ifndef DETECTOR_PARAMS_SVH
`define DETECTOR_PARAMS_SVH

// symbols per chunk
`define CHUNK_W    8

// samples summed per hypothesis
`define SEQ_LEN    3

// chunks held in the history, index 0 being the oldest
`define HIST_DEPTH 3
`define T0_BUFF    1

`define ERR_BITS   8
`define TAP_BITS   8
`define SQR_BITS   20
`define SUM_BITS   22

// width of the corrected-chunk counter
`define CNT_BITS   16

`endif

//--- hw/dsp_pkg.sv
`include "detector_params.svh"

package dsp_pkg;

    typedef logic signed [`ERR_BITS-1:0] err_t;
    typedef logic signed [`TAP_BITS-1:0] tap_t;
    typedef logic [`SQR_BITS-1:0] sqr_t;
    typedef logic [`SUM_BITS-1:0] sum_t;

    // symbol 0 is the earliest one in the chunk
    typedef struct packed {
        logic [`CHUNK_W-1:0] bits;
        err_t [`CHUNK_W-1:0] err;
    } chunk_t;

    // tap 0 is the main cursor
    typedef tap_t [`SEQ_LEN:0] taps_t;

    typedef enum logic [1:0] {
        hyp_none        = 2'd0,
        hyp_single_cur  = 2'd1,
        hyp_single_prev = 2'd2,
        hyp_double      = 2'd3
    } hyp_e;

    typedef hyp_e [`CHUNK_W-1:0] decision_t;

    // err[p][j] is sample p + j counted from the start of the evaluated chunk
    typedef err_t [`CHUNK_W-1:0][`SEQ_LEN-1:0] win_err_t;

    // bits[0] is the last decision of the preceding chunk
    typedef struct packed {
        win_err_t          err;
        logic [`CHUNK_W:0] bits;
    } window_t;

endpackage

//--- hw/csr_pkg.sv
package csr_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        reg_taps  = 2'd0,
        reg_ctrl  = 2'd1,
        reg_count = 2'd2
    } reg_addr_e;

    typedef struct packed {
        logic [29:0] reserved;
        logic        clear_count;
        logic        enable;
    } ctrl_t;

    // the same data word holds the taps or the control fields
    typedef union packed {
        dsp_pkg::taps_t taps;
        ctrl_t          ctrl;
    } csr_word_u;

endpackage

//--- hw/channel_csr.sv
`include "detector_params.svh"

module channel_csr (
    input  logic             clk,
    input  logic             rst,
    input  csr_pkg::wb_req_t wb_req,
    output csr_pkg::wb_rsp_t wb_rsp,
    input  logic             corrected,
    output dsp_pkg::taps_t   taps,
    output logic             enable
);
    import csr_pkg::*;

    reg_addr_e                    addr;
    csr_word_u                    wr_word;
    csr_word_u                    rd_word;
    logic [$bits(csr_word_u)-1:0] rd_q;
    logic                         ack;
    logic                         req;
    logic                         clear;
    logic [`CNT_BITS-1:0]         count;

    // a new request is taken only when no ack is pending
    assign req     = wb_req.cyc && wb_req.stb && !ack;
    assign addr    = reg_addr_e'(wb_req.adr);
    assign wr_word = wb_req.dat;
    assign clear   = req && wb_req.we && addr == reg_ctrl && wr_word.ctrl.clear_count;

    always_comb begin
        rd_word = '0;
        case (addr)
            reg_taps: begin
                rd_word.taps = taps;
            end
            reg_ctrl: begin
                rd_word.ctrl.enable = enable;
            end
            reg_count: begin
                rd_word = $bits(csr_word_u)'(count);
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack    <= 1'b0;
            taps   <= '0;
            enable <= 1'b0;
            count  <= '0;
        end else begin
            ack <= req;
            if (req && wb_req.we) begin
                case (addr)
                    reg_taps: taps   <= wr_word.taps;
                    reg_ctrl: enable <= wr_word.ctrl.enable;
                    default: ;
                endcase
            end
            // saturates at the top instead of wrapping
            if (clear) begin
                count <= '0;
            end else if (corrected && count != '1) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rd_q <= rd_word;
        end
    end

    assign wb_rsp = '{ack: ack, dat: rd_q};

endmodule

//--- hw/chunk_history.sv
`include "detector_params.svh"

module chunk_history (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  dsp_pkg::chunk_t     in_chunk,
    output dsp_pkg::window_t    window,
    output logic [`CHUNK_W-1:0] eval_bits,
    output logic                eval_valid
);
    import dsp_pkg::*;

    localparam int fill_bits = $clog2(`HIST_DEPTH + 1);

    chunk_t               hist   [`HIST_DEPTH];
    err_t                 stream [`HIST_DEPTH*`CHUNK_W];
    logic [fill_bits-1:0] fill;
    logic                 prev_bit;

    // newest chunk enters at the top and the oldest falls out at index 0
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int c = 0; c < `HIST_DEPTH - 1; c++) begin
                hist[c] <= hist[c+1];
            end
            hist[`HIST_DEPTH-1] <= in_chunk;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill       <= '0;
            eval_valid <= 1'b0;
        end else begin
            eval_valid <= in_valid && fill >= fill_bits'(`HIST_DEPTH - `T0_BUFF - 1);
            if (in_valid && fill != fill_bits'(`HIST_DEPTH)) begin
                fill <= fill + 1'b1;
            end
        end
    end

    // the first evaluated chunk has no predecessor, so its previous decision reads as 0
    assign prev_bit = (fill == fill_bits'(`HIST_DEPTH)) ?
                      hist[`T0_BUFF-1].bits[`CHUNK_W-1] : 1'b0;

    always_comb begin
        for (int c = 0; c < `HIST_DEPTH; c++) begin
            for (int i = 0; i < `CHUNK_W; i++) begin
                stream[c*`CHUNK_W+i] = hist[c].err[i];
            end
        end
        for (int p = 0; p < `CHUNK_W; p++) begin
            for (int j = 0; j < `SEQ_LEN; j++) begin
                window.err[p][j] = stream[`T0_BUFF*`CHUNK_W+p+j];
            end
            window.bits[p+1] = hist[`T0_BUFF].bits[p];
        end
        window.bits[0] = prev_bit;
    end

    assign eval_bits = hist[`T0_BUFF].bits;

endmodule

//--- hw/sliding_detector.sv
`include "detector_params.svh"

module sliding_detector (
    input  dsp_pkg::window_t   window,
    input  dsp_pkg::taps_t     taps,
    output dsp_pkg::decision_t decision
);
    import dsp_pkg::*;

    // a residual plus two injected taps fits in half the square width
    localparam int acc_bits = `SQR_BITS / 2;

    typedef logic signed [acc_bits-1:0] acc_t;

    acc_t iev_prev [`CHUNK_W][`SEQ_LEN];
    acc_t iev_cur  [`CHUNK_W][`SEQ_LEN];
    acc_t hyp_err  [`CHUNK_W][4][`SEQ_LEN];
    sum_t mse      [`CHUNK_W][4];

    // widen before negating so that the most negative tap stays exact
    function automatic acc_t inject(tap_t tap, logic bit_val);
        acc_t t;
        t = acc_t'(tap);
        return bit_val ? -t : t;
    endfunction

    function automatic sqr_t square(acc_t v);
        logic signed [`SQR_BITS-1:0] w;
        w = v;
        return sqr_t'(w * w);
    endfunction

    always_comb begin
        acc_t e;
        hyp_e best;

        // symbol p sits at bits[p+1] and lands with tap t on sample p + 1 + t
        for (int p = 0; p < `CHUNK_W; p++) begin
            for (int j = 0; j < `SEQ_LEN; j++) begin
                iev_prev[p][j] = inject(taps[j], window.bits[p]);
                iev_cur[p][j]  = inject(taps[j], window.bits[p+1]);
            end
        end

        for (int p = 0; p < `CHUNK_W; p++) begin
            for (int j = 0; j < `SEQ_LEN; j++) begin
                e = acc_t'(window.err[p][j]);
                hyp_err[p][hyp_none][j]        = e;
                hyp_err[p][hyp_single_prev][j] = e + iev_prev[p][j];
                if (j == 0) begin
                    hyp_err[p][hyp_single_cur][j] = e;
                    hyp_err[p][hyp_double][j]     = e + iev_prev[p][0];
                end else begin
                    hyp_err[p][hyp_single_cur][j] = e + iev_cur[p][j-1];
                    hyp_err[p][hyp_double][j]     = e + iev_cur[p][j-1] + iev_prev[p][j];
                end
            end
        end

        for (int p = 0; p < `CHUNK_W; p++) begin
            for (int h = 0; h < 4; h++) begin
                mse[p][h] = '0;
                for (int j = 0; j < `SEQ_LEN; j++) begin
                    mse[p][h] = mse[p][h] + sum_t'(square(hyp_err[p][h][j]));
                end
            end
        end

        // strict comparison keeps the lower hypothesis on a tie
        for (int p = 0; p < `CHUNK_W; p++) begin
            best = hyp_none;
            for (int h = 1; h < 4; h++) begin
                if (mse[p][h] < mse[p][best]) begin
                    best = hyp_e'(h);
                end
            end
            decision[p] = best;
        end
    end

endmodule

//--- hw/error_corrector.sv
`include "detector_params.svh"

module error_corrector (
    input  logic                clk,
    input  logic                rst,
    input  logic                eval_valid,
    input  logic [`CHUNK_W-1:0] eval_bits,
    input  dsp_pkg::win_err_t   eval_errors,
    input  dsp_pkg::decision_t  decision,
    input  logic                enable,
    output logic                out_valid,
    output dsp_pkg::chunk_t     out_chunk,
    output logic                corrected
);
    import dsp_pkg::*;

    logic [`CHUNK_W-1:0] flip;
    logic [`CHUNK_W-1:0] fixed_bits;

    always_comb begin
        // a position names its own symbol for single_cur and double
        for (int i = 0; i < `CHUNK_W; i++) begin
            flip[i] = decision[i] == hyp_single_cur || decision[i] == hyp_double;
        end
        // the next position names this symbol as its previous one
        for (int i = 0; i < `CHUNK_W - 1; i++) begin
            if (decision[i+1] == hyp_single_prev || decision[i+1] == hyp_double) begin
                flip[i] = 1'b1;
            end
        end
    end

    // position 0 may point into the chunk already sent, and that is left alone
    assign fixed_bits = enable ? eval_bits ^ flip : eval_bits;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            corrected <= 1'b0;
        end else begin
            out_valid <= eval_valid;
            corrected <= eval_valid && enable && |flip;
        end
    end

    always_ff @(posedge clk) begin
        if (eval_valid) begin
            out_chunk.bits <= fixed_bits;
            for (int i = 0; i < `CHUNK_W; i++) begin
                out_chunk.err[i] <= eval_errors[i][0];
            end
        end
    end

endmodule

//--- hw/mmse_postproc_top.sv
`include "detector_params.svh"

module mmse_postproc_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  dsp_pkg::chunk_t  in_chunk,
    output logic             out_valid,
    output dsp_pkg::chunk_t  out_chunk,
    input  csr_pkg::wb_req_t wb_req,
    output csr_pkg::wb_rsp_t wb_rsp
);
    import dsp_pkg::*;

    window_t             window;
    logic [`CHUNK_W-1:0] eval_bits;
    logic                eval_valid;
    taps_t               taps;
    logic                enable;
    decision_t           decision;
    logic                corrected;

    chunk_history u_history (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_chunk   (in_chunk),
        .window     (window),
        .eval_bits  (eval_bits),
        .eval_valid (eval_valid)
    );

    sliding_detector u_detector (
        .window   (window),
        .taps     (taps),
        .decision (decision)
    );

    error_corrector u_corrector (
        .clk         (clk),
        .rst         (rst),
        .eval_valid  (eval_valid),
        .eval_bits   (eval_bits),
        .eval_errors (window.err),
        .decision    (decision),
        .enable      (enable),
        .out_valid   (out_valid),
        .out_chunk   (out_chunk),
        .corrected   (corrected)
    );

    channel_csr u_csr (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .corrected (corrected),
        .taps      (taps),
        .enable    (enable)
    );

endmodule

//--- bench/mmse_postproc_assertions.sv
module mmse_postproc_assertions (
    input logic             clk,
    input logic             rst,
    input csr_pkg::wb_req_t wb_req,
    input csr_pkg::wb_rsp_t wb_rsp,
    input logic             out_valid,
    input dsp_pkg::chunk_t  out_chunk
);

    // the slave may only answer a cycle that is still open
    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
        else $error("ack high without cyc and stb");

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack held for more than one cycle");

    out_quiet_in_reset: assert property (@(posedge clk)
        rst |=> !out_valid)
        else $error("out_valid high while in reset");

    // a valid output chunk must carry no X or Z
    out_known: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown(out_chunk))
        else $error("out_chunk unknown while out_valid is high");

endmodule

bind mmse_postproc_top mmse_postproc_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .out_valid (out_valid),
    .out_chunk (out_chunk)
);

//--- bench/mmse_postproc_tb.sv
`include "detector_params.svh"

module mmse_postproc_tb;
    import dsp_pkg::*;
    import csr_pkg::*;

    logic        clk;
    logic        rst;
    logic        in_valid;
    chunk_t      in_chunk;
    logic        out_valid;
    chunk_t      out_chunk;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;

    logic [31:0] rng_state;
    taps_t       cur_taps;
    logic        cur_enable;
    chunk_t      prev_chunk;
    chunk_t      last_chunk;
    chunk_t      last_expected;
    chunk_t      exp_q [$];
    int          n_sent;
    int          ref_count;
    int          outputs_seen;
    int          checks;
    int          errors;
    int          tests;

    mmse_postproc_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_chunk  (in_chunk),
        .out_valid (out_valid),
        .out_chunk (out_chunk),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic chunk_t rand_chunk();
        chunk_t      c;
        logic [31:0] w;
        w = next_rand();
        c.bits = w[`CHUNK_W-1:0];
        c.err  = {next_rand(), next_rand()};
        return c;
    endfunction

    // a decided 1 pulls the residual down by its tap, a decided 0 pushes it up
    function automatic int tap_push(input tap_t tap, input logic b);
        return b ? -int'(tap) : int'(tap);
    endfunction

    function automatic chunk_t model_chunk(input logic prev_bit, input chunk_t cur,
                                           input chunk_t nxt, input taps_t tp, input logic en);
        int                samp [`CHUNK_W+`SEQ_LEN-1];
        logic [`CHUNK_W:0] b;
        int                sums [4];
        hyp_e              pick [`CHUNK_W];
        int                v;
        logic              flip;
        chunk_t            res;
        for (int s = 0; s < `CHUNK_W + `SEQ_LEN - 1; s++) begin
            samp[s] = (s < `CHUNK_W) ? int'(cur.err[s]) : int'(nxt.err[s-`CHUNK_W]);
        end
        b = {cur.bits, prev_bit};
        for (int p = 0; p < `CHUNK_W; p++) begin
            for (int h = 0; h < 4; h++) begin
                sums[h] = 0;
                for (int j = 0; j < `SEQ_LEN; j++) begin
                    v = samp[p+j];
                    // symbol p-1 reaches sample p+j through tap j and symbol p through tap j-1
                    if (h == hyp_single_prev || h == hyp_double) begin
                        v = v + tap_push(tp[j], b[p]);
                    end
                    if ((h == hyp_single_cur || h == hyp_double) && j > 0) begin
                        v = v + tap_push(tp[j-1], b[p+1]);
                    end
                    sums[h] = sums[h] + v * v;
                end
            end
            pick[p] = hyp_none;
            for (int h = 1; h < 4; h++) begin
                if (sums[h] < sums[pick[p]]) begin
                    pick[p] = hyp_e'(h);
                end
            end
        end
        res = cur;
        for (int i = 0; i < `CHUNK_W; i++) begin
            flip = pick[i] == hyp_single_cur || pick[i] == hyp_double;
            if (i < `CHUNK_W - 1) begin
                flip = flip || pick[i+1] == hyp_single_prev || pick[i+1] == hyp_double;
            end
            if (en && flip) begin
                res.bits[i] = ~cur.bits[i];
            end
        end
        return res;
    endfunction

    // the chunk sent before this one is now complete and can be predicted
    task automatic send_chunk(input chunk_t c);
        chunk_t want;
        @(posedge clk);
        #1;
        if (n_sent >= 1) begin
            want = model_chunk(n_sent >= 2 ? prev_chunk.bits[`CHUNK_W-1] : 1'b0,
                               last_chunk, c, cur_taps, cur_enable);
            exp_q.push_back(want);
            if (want.bits != last_chunk.bits) begin
                ref_count++;
            end
            last_expected = want;
        end
        prev_chunk = last_chunk;
        last_chunk = c;
        n_sent++;
        in_valid = 1'b1;
        in_chunk = c;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic run_stream(input int count, input logic bursty);
        int sent;
        sent = 0;
        while (sent < count) begin
            if (bursty && next_rand() % 4 == 0) begin
                idle_cycle();
            end else begin
                send_chunk(rand_chunk());
                sent++;
            end
        end
        idle_cycle();
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 60) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d expected chunks never reached the output", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic wb_cycle(input logic we, input reg_addr_e adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        int cycles;
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!wb_rsp.ack && cycles < 20);
        if (!wb_rsp.ack) begin
            $display("Timeout: no ack for Wishbone access to address %0d", adr);
            errors++;
        end
        rdat = wb_rsp.dat;
        // the master keeps the cycle open across the edge where ack is sampled
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_write(input reg_addr_e adr, input logic [31:0] dat);
        logic [31:0] rd_ignored;
        wb_cycle(1'b1, adr, dat, rd_ignored);
        case (adr)
            reg_taps: cur_taps = dat;
            reg_ctrl: begin
                cur_enable = dat[0];
                if (dat[1]) begin
                    ref_count = 0;
                end
            end
            default: ;
        endcase
    endtask

    task automatic expect_reg(input reg_addr_e adr, input logic [31:0] want, input string name);
        logic [31:0] got;
        wb_cycle(1'b0, adr, 32'h0, got);
        checks++;
        if (got !== want) begin
            $display("Fail t=%0t %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    // one error event per chunk, with residuals that the injected decision errors explain
    task automatic run_directed();
        logic [`CHUNK_W-1:0] orig  [24];
        logic [`CHUNK_W-1:0] flips [24];
        int                  errs  [24*`CHUNK_W+`SEQ_LEN+1];
        chunk_t              c;
        int                  m;
        int                  s;
        for (int k = 0; k < 24; k++) begin
            orig[k]  = `CHUNK_W'(next_rand());
            flips[k] = '0;
            if (k % 4 == 1) begin
                m = next_rand() % 6;
                flips[k][m] = 1'b1;
            end else if (k % 4 == 2) begin
                m = 1 + next_rand() % 4;
                flips[k][m]   = 1'b1;
                flips[k][m+1] = 1'b1;
            end
        end
        for (int i = 0; i < 24 * `CHUNK_W + `SEQ_LEN + 1; i++) begin
            errs[i] = int'(next_rand() % 3) - 1;
        end
        for (int k = 0; k < 24; k++) begin
            for (int i = 0; i < `CHUNK_W; i++) begin
                if (flips[k][i]) begin
                    for (int t = 0; t <= `SEQ_LEN; t++) begin
                        s = k * `CHUNK_W + i + 1 + t;
                        errs[s] = errs[s] - tap_push(cur_taps[t], ~orig[k][i]);
                    end
                end
            end
        end
        for (int k = 0; k < 24; k++) begin
            c.bits = orig[k] ^ flips[k];
            for (int i = 0; i < `CHUNK_W; i++) begin
                c.err[i] = err_t'(errs[k*`CHUNK_W+i]);
            end
            send_chunk(c);
            if (k > 0) begin
                checks++;
                if (last_expected.bits !== orig[k-1]) begin
                    $display("Fail t=%0t recovered bits got %h expected %h",
                             $time, last_expected.bits, orig[k-1]);
                    errors++;
                end
            end
        end
        idle_cycle();
    endtask

    task automatic finish_test(input string name, input int mark);
        tests++;
        if (errors == mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - mark);
        end
    endtask

    always @(posedge clk) begin : compare_outputs
        chunk_t want;
        if (!rst && out_valid) begin
            outputs_seen++;
            checks++;
            if (exp_q.size() == 0) begin
                $display("Fail at t=%0t: an output chunk came out that was not expected", $time);
                errors++;
            end else begin
                want = exp_q.pop_front();
                if (out_chunk.bits !== want.bits) begin
                    $display("Fail t=%0t out_chunk.bits got %h expected %h",
                             $time, out_chunk.bits, want.bits);
                    errors++;
                end
                if (out_chunk.err !== want.err) begin
                    $display("Fail t=%0t out_chunk.err got %h expected %h",
                             $time, out_chunk.err, want.err);
                    errors++;
                end
            end
        end
    end

    initial begin
        logic [31:0] word;
        int          mark;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_chunk     = '0;
        wb_req       = '0;
        rng_state    = 32'h24d52f59;
        cur_taps     = '0;
        cur_enable   = 1'b0;
        n_sent       = 0;
        ref_count    = 0;
        outputs_seen = 0;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        mark = errors;
        checks++;
        if (out_valid !== 1'b0) begin
            $display("Fail t=%0t out_valid got %b expected 0", $time, out_valid);
            errors++;
        end
        expect_reg(reg_taps, 32'h0, "reg_taps");
        expect_reg(reg_ctrl, 32'h0, "reg_ctrl");
        expect_reg(reg_count, 32'h0, "reg_count");
        word = next_rand();
        wb_write(reg_taps, word);
        expect_reg(reg_taps, word, "reg_taps");
        wb_write(reg_ctrl, 32'h3);
        expect_reg(reg_ctrl, 32'h1, "reg_ctrl");
        wb_write(reg_ctrl, 32'h0);
        expect_reg(reg_ctrl, 32'h0, "reg_ctrl");
        finish_test("reset and register access", mark);

        mark = errors;
        run_stream(30, 1'b0);
        wait_drain();
        repeat (6) idle_cycle();
        // the newest chunk stays held until a successor arrives
        checks++;
        if (outputs_seen != n_sent - 1) begin
            $display("Fail t=%0t outputs_seen got %0d expected %0d", $time, outputs_seen,
                     n_sent - 1);
            errors++;
        end
        finish_test("pass-through with enable off", mark);

        mark = errors;
        wb_write(reg_taps, 32'h0008_1030);
        wb_write(reg_ctrl, 32'h1);
        run_directed();
        wait_drain();
        finish_test("directed error correction", mark);

        mark = errors;
        wb_write(reg_taps, next_rand());
        run_stream(200, 1'b1);
        wait_drain();
        finish_test("random taps and bursty stream", mark);

        mark = errors;
        wb_write(reg_taps, 32'h0008_1030);
        wb_write(reg_ctrl, 32'h3);
        run_stream(40, 1'b1);
        wait_drain();
        expect_reg(reg_count, ref_count, "reg_count");
        wb_write(reg_ctrl, 32'h3);
        expect_reg(reg_count, 32'h0, "reg_count");
        finish_test("corrected chunk count", mark);

        mark = errors;
        wb_write(reg_count, 32'h0000_5a5a);
        expect_reg(reg_count, ref_count, "reg_count");
        fork
            run_stream(60, 1'b1);
            begin
                repeat (4) begin
                    expect_reg(reg_taps, cur_taps, "reg_taps");
                    expect_reg(reg_ctrl, 32'h1, "reg_ctrl");
                end
                wb_write(reg_count, 32'h0000_ffff);
            end
        join
        wait_drain();
        expect_reg(reg_count, ref_count, "reg_count");
        finish_test("register access during traffic", mark);

        $display("tests %0d, checks %0d, chunks out %0d, errors %0d",
                 tests, checks, outputs_seen, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hw
hw/dsp_pkg.sv
hw/csr_pkg.sv
hw/channel_csr.sv
hw/chunk_history.sv
hw/sliding_detector.sv
hw/error_corrector.sv
hw/mmse_postproc_top.sv
bench/mmse_postproc_assertions.sv
bench/mmse_postproc_tb.sv
